// File: src/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// ========================================
// Issue stage widths and counts
// ========================================

// Slots renamed per cycle
`define ISSUE_WIDTH 3

// Architectural register file
`define ARCH_REGS   32
`define ARCH_ADDR_W 5

// Physical register file
`define PHYS_REGS   64
`define PHYS_ADDR_W 6

// Instruction word and pc
`define XLEN 32

`endif

// File: src/issue_pkg.sv
`include "issue_macros.svh"

package issue_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // One instruction word seen as register format or as store/branch format
    typedef union packed {
        struct packed {
            logic [6:0]              funct7;
            logic [`ARCH_ADDR_W-1:0] rs2;
            logic [`ARCH_ADDR_W-1:0] rs1;
            logic [2:0]              funct3;
            logic [`ARCH_ADDR_W-1:0] rd;
            logic [6:0]              opcode;
        } r;
        struct packed {
            logic [6:0]              imm_hi;
            logic [`ARCH_ADDR_W-1:0] rs2;
            logic [`ARCH_ADDR_W-1:0] rs1;
            logic [2:0]              funct3;
            logic [4:0]              imm_lo;
            logic [6:0]              opcode;
        } s;
    } instr_word_u;

    // Incoming fetch slot
    typedef struct packed {
        instr_word_u      instr;
        logic [`XLEN-1:0] pc;
    } fetch_slot_t;

    // Decoder result per lane
    typedef struct packed {
        logic [`ARCH_ADDR_W-1:0] rs1;
        logic [`ARCH_ADDR_W-1:0] rs2;
        logic [`ARCH_ADDR_W-1:0] rd;
        logic                    rd_we;
        opcode_e                 opcode;
    } dec_fields_t;

    // Renamed micro-op towards dispatch
    typedef struct packed {
        logic [`XLEN-1:0]        pc;
        logic [`PHYS_ADDR_W-1:0] rs1_phys;
        logic [`PHYS_ADDR_W-1:0] rs2_phys;
        logic [`PHYS_ADDR_W-1:0] rd_phys;
        logic [`ARCH_ADDR_W-1:0] rd_arch;
        logic                    rd_we;
        opcode_e                 opcode;
    } issue_uop_t;

endpackage

// File: src/issue_decoder.sv
`timescale 1ns/1ps

module issue_decoder (
    input  issue_pkg::fetch_slot_t slot_i,
    output issue_pkg::dec_fields_t fields_o
);
    import issue_pkg::*;

    instr_word_u instr;
    opcode_e     opcode;
    logic [4:0]  src1;
    logic [4:0]  src2;
    logic        uses_rs1;
    logic        writes_rd;

    assign instr  = slot_i.instr;
    assign opcode = opcode_e'(instr.r.opcode);

    // Register usage by major opcode
    always_comb begin
        uses_rs1  = 1'b1;
        writes_rd = 1'b0;
        src2      = '0;
        case (opcode)
            OP: begin
                writes_rd = 1'b1;
                src2      = instr.r.rs2;
            end
            OP_IMM, LOAD, JALR: begin
                writes_rd = 1'b1;
            end
            LUI, AUIPC, JAL: begin
                // Upper immediate and jump formats carry no rs1
                uses_rs1  = 1'b0;
                writes_rd = 1'b1;
            end
            STORE, BRANCH: begin
                // Bits [11:7] hold immediate here, not rd
                src2 = instr.s.rs2;
            end
            default: begin
                // SYSTEM and unknown opcodes write nothing
                writes_rd = 1'b0;
            end
        endcase
    end

    assign src1 = uses_rs1 ? instr.r.rs1 : 5'd0;

    // x0 as destination never allocates
    assign fields_o = '{
        rs1:    src1,
        rs2:    src2,
        rd:     instr.r.rd,
        rd_we:  writes_rd && (instr.r.rd != 5'd0),
        opcode: opcode
    };

endmodule

// File: src/rename_map.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module rename_map (
    input  logic                        clk,
    input  logic                        reset,
    input  issue_pkg::dec_fields_t      fields_i   [`ISSUE_WIDTH],
    input  logic [`ISSUE_WIDTH-1:0]     accept_i,
    input  logic [`PHYS_ADDR_W-1:0]     heads_i    [`ISSUE_WIDTH],
    output logic [`PHYS_ADDR_W-1:0]     rs1_phys_o [`ISSUE_WIDTH],
    output logic [`PHYS_ADDR_W-1:0]     rs2_phys_o [`ISSUE_WIDTH],
    output logic [`PHYS_ADDR_W-1:0]     rd_phys_o  [`ISSUE_WIDTH],
    output logic [1:0]                  pop_count_o
);
    localparam int unsigned PW = `PHYS_ADDR_W;

    // Alias table, one physical tag per architectural register
    logic [PW-1:0]           map [`ARCH_REGS];
    logic [`ISSUE_WIDTH-1:0] alloc;
    logic [1:0]              pops;

    // ========================================
    // Destination allocation
    // ========================================

    // Only accepted lanes with a real destination take a free register
    always_comb begin
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            alloc[k] = accept_i[k] && fields_i[k].rd_we;
        end
    end

    // Writing lanes take heads in lane order, skipping lanes that allocate nothing
    always_comb begin
        pops = 2'd0;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            rd_phys_o[k] = '0;
            if (alloc[k]) begin
                rd_phys_o[k] = heads_i[pops];
                pops         = pops + 2'd1;
            end
        end
    end

    assign pop_count_o = pops;

    // ========================================
    // Source lookup with group bypass
    // ========================================

    // Start from the table, then let each earlier writer override
    // Ascending j leaves the newest earlier writer in place
    always_comb begin
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            rs1_phys_o[k] = map[fields_i[k].rs1];
            rs2_phys_o[k] = map[fields_i[k].rs2];
            for (int j = 0; j < k; j++) begin
                if (alloc[j] && (fields_i[j].rd == fields_i[k].rs1)) begin
                    rs1_phys_o[k] = rd_phys_o[j];
                end
                if (alloc[j] && (fields_i[j].rd == fields_i[k].rs2)) begin
                    rs2_phys_o[k] = rd_phys_o[j];
                end
            end
        end
    end

    // ========================================
    // Table update
    // ========================================

    // Identity mapping out of reset
    // A later lane writing the same rd wins by statement order
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= PW'(i);
            end
        end else begin
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                if (alloc[k]) begin
                    map[fields_i[k].rd] <= rd_phys_o[k];
                end
            end
        end
    end

endmodule

// File: src/free_list.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module free_list (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [1:0]                  pop_count_i,
    input  logic [`ISSUE_WIDTH-1:0]     commit_valid_i,
    input  logic [`PHYS_ADDR_W-1:0]     commit_addr_i [`ISSUE_WIDTH],
    output logic [`PHYS_ADDR_W-1:0]     heads_o       [`ISSUE_WIDTH],
    output logic                        free_ok_o
);
    localparam int unsigned PW        = `PHYS_ADDR_W;
    localparam int unsigned CW        = `PHYS_ADDR_W + 1;
    localparam int unsigned INIT_FREE = `PHYS_REGS - `ARCH_REGS;

    // Ring of free tags, pointers wrap naturally at 64
    logic [PW-1:0] fifo [`PHYS_REGS];
    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [CW-1:0] count;
    logic [PW-1:0] push_ptr [`ISSUE_WIDTH];
    logic [1:0]    push_count;

    // Next three free tags in FIFO order
    for (genvar k = 0; k < `ISSUE_WIDTH; k++) begin : g_head
        assign heads_o[k] = fifo[head + PW'(k)];
    end

    // Enough room for a full group of writers
    assign free_ok_o = (count >= CW'(`ISSUE_WIDTH));

    // Commits pack behind the tail in lane order
    always_comb begin
        push_count = 2'd0;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            push_ptr[k] = tail + PW'(push_count);
            push_count  = push_count + 2'(commit_valid_i[k]);
        end
    end

    // ========================================
    // Storage and pointers
    // ========================================

    // Tags 32..63 start free, 0..31 back the identity map
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                fifo[i] <= (i < INIT_FREE) ? PW'(i + `ARCH_REGS) : '0;
            end
            head  <= '0;
            tail  <= PW'(INIT_FREE);
            count <= CW'(INIT_FREE);
        end else begin
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                if (commit_valid_i[k]) begin
                    fifo[push_ptr[k]] <= commit_addr_i[k];
                end
            end
            head  <= head + PW'(pop_count_i);
            tail  <= tail + PW'(push_count);
            // Pops and pushes of the same cycle net out
            count <= count + CW'(push_count) - CW'(pop_count_i);
        end
    end

endmodule

// File: src/issue_pipe_reg.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_pipe_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`ISSUE_WIDTH-1:0]     decode_valid_i,
    input  logic [`ISSUE_WIDTH-1:0]     dispatch_ready_i,
    input  logic                        free_ok_i,
    input  logic                        flush_i,
    input  logic                        bubble_i,
    input  issue_pkg::issue_uop_t       uop_i [`ISSUE_WIDTH],
    output logic [`ISSUE_WIDTH-1:0]     accept_o,
    output logic [`ISSUE_WIDTH-1:0]     decode_ready_o,
    output logic [`ISSUE_WIDTH-1:0]     dispatch_valid_o,
    output issue_pkg::issue_uop_t       uop_o [`ISSUE_WIDTH]
);
    logic kill;

    // ========================================
    // Handshake
    // ========================================

    assign kill = flush_i | bubble_i;

    // A lane is ready when dispatch takes it and a full group can allocate
    assign decode_ready_o = dispatch_ready_i & {`ISSUE_WIDTH{free_ok_i}};

    // Flush and bubble squash the whole group
    assign accept_o = decode_valid_i & decode_ready_o & {`ISSUE_WIDTH{~kill}};

    // ========================================
    // Output registers
    // ========================================

    // Valid follows acceptance by one cycle
    // Stall, flush, bubble and empty slots all leave it low
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dispatch_valid_o <= '0;
        end else begin
            dispatch_valid_o <= accept_o;
        end
    end

    // Payload per lane, held until the lane accepts again
    for (genvar k = 0; k < `ISSUE_WIDTH; k++) begin : g_lane
        always_ff @(posedge clk) begin
            if (accept_o[k]) begin
                uop_o[k] <= uop_i[k];
            end
        end
    end

endmodule

// File: src/issue_stage.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  issue_pkg::fetch_slot_t      slots_i [`ISSUE_WIDTH],
    input  logic [`ISSUE_WIDTH-1:0]     decode_valid_i,
    output logic [`ISSUE_WIDTH-1:0]     decode_ready_o,
    input  logic [`ISSUE_WIDTH-1:0]     dispatch_ready_i,
    input  logic                        flush_i,
    input  logic                        bubble_i,
    input  logic [`ISSUE_WIDTH-1:0]     commit_valid_i,
    input  logic [`PHYS_ADDR_W-1:0]     commit_addr_i [`ISSUE_WIDTH],
    output logic [`ISSUE_WIDTH-1:0]     dispatch_valid_o,
    output issue_pkg::issue_uop_t       uop_o [`ISSUE_WIDTH]
);
    import issue_pkg::*;

    dec_fields_t             fields   [`ISSUE_WIDTH];
    issue_uop_t              uop_d    [`ISSUE_WIDTH];
    logic [`PHYS_ADDR_W-1:0] rs1_phys [`ISSUE_WIDTH];
    logic [`PHYS_ADDR_W-1:0] rs2_phys [`ISSUE_WIDTH];
    logic [`PHYS_ADDR_W-1:0] rd_phys  [`ISSUE_WIDTH];
    logic [`PHYS_ADDR_W-1:0] heads    [`ISSUE_WIDTH];
    logic [`ISSUE_WIDTH-1:0] accept;
    logic [1:0]              pop_count;
    logic                    free_ok;

    // ========================================
    // Decode and uop assembly per lane
    // ========================================

    for (genvar k = 0; k < `ISSUE_WIDTH; k++) begin : g_lane
        issue_decoder u_dec (
            .slot_i   (slots_i[k]),
            .fields_o (fields[k])
        );

        assign uop_d[k] = '{
            pc:       slots_i[k].pc,
            rs1_phys: rs1_phys[k],
            rs2_phys: rs2_phys[k],
            rd_phys:  rd_phys[k],
            rd_arch:  fields[k].rd,
            rd_we:    fields[k].rd_we,
            opcode:   fields[k].opcode
        };
    end

    // ========================================
    // Rename state
    // ========================================

    rename_map u_map (
        .clk         (clk),
        .reset       (reset),
        .fields_i    (fields),
        .accept_i    (accept),
        .heads_i     (heads),
        .rs1_phys_o  (rs1_phys),
        .rs2_phys_o  (rs2_phys),
        .rd_phys_o   (rd_phys),
        .pop_count_o (pop_count)
    );

    free_list u_free (
        .clk            (clk),
        .reset          (reset),
        .pop_count_i    (pop_count),
        .commit_valid_i (commit_valid_i),
        .commit_addr_i  (commit_addr_i),
        .heads_o        (heads),
        .free_ok_o      (free_ok)
    );

    // Acceptance and dispatch registers
    issue_pipe_reg u_pipe (
        .clk              (clk),
        .reset            (reset),
        .decode_valid_i   (decode_valid_i),
        .dispatch_ready_i (dispatch_ready_i),
        .free_ok_i        (free_ok),
        .flush_i          (flush_i),
        .bubble_i         (bubble_i),
        .uop_i            (uop_d),
        .accept_o         (accept),
        .decode_ready_o   (decode_ready_o),
        .dispatch_valid_o (dispatch_valid_o),
        .uop_o            (uop_o)
    );

endmodule

// File: testbench/issue_stage_props.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_stage_props (
    input logic                          clk,
    input logic                          reset,
    input logic                          flush_i,
    input logic                          bubble_i,
    input logic [`ISSUE_WIDTH-1:0]       dispatch_ready_i,
    input logic [`ISSUE_WIDTH-1:0]       decode_ready_o,
    input logic [`ISSUE_WIDTH-1:0]       dispatch_valid_o,
    input issue_pkg::issue_uop_t         uop_o [`ISSUE_WIDTH]
);
    // Squash reaches the outputs one cycle later
    a_kill_clears_valid: assert property (
        @(posedge clk) disable iff (!reset)
        (flush_i || bubble_i) |=> (dispatch_valid_o == '0)
    ) else $error("dispatch valid set the cycle after flush or bubble");

    a_ready_needs_dispatch: assert property (
        @(posedge clk) disable iff (!reset)
        ((decode_ready_o & ~dispatch_ready_i) == '0)
    ) else $error("decode ready set on a lane whose dispatch ready is low");

    // Tag 0 stays bound to x0
    for (genvar k = 0; k < `ISSUE_WIDTH; k++) begin : g_lane
        a_writer_has_tag: assert property (
            @(posedge clk) disable iff (!reset)
            (dispatch_valid_o[k] && uop_o[k].rd_we) |-> (uop_o[k].rd_phys != '0)
        ) else $error("lane %0d dispatched a writer with physical tag 0", k);
    end

endmodule

bind issue_stage issue_stage_props u_props (
    .clk              (clk),
    .reset            (reset),
    .flush_i          (flush_i),
    .bubble_i         (bubble_i),
    .dispatch_ready_i (dispatch_ready_i),
    .decode_ready_o   (decode_ready_o),
    .dispatch_valid_o (dispatch_valid_o),
    .uop_o            (uop_o)
);

// File: testbench/issue_stage_tb.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_stage_tb;
    import issue_pkg::*;

    localparam int W           = `ISSUE_WIDTH;
    localparam int PW          = `PHYS_ADDR_W;
    localparam int CYCLE_LIMIT = 2000;

    logic                clk;
    logic                reset;
    fetch_slot_t         slots_i [W];
    logic [W-1:0]        decode_valid_i;
    logic [W-1:0]        decode_ready_o;
    logic [W-1:0]        dispatch_ready_i;
    logic                flush_i;
    logic                bubble_i;
    logic [W-1:0]        commit_valid_i;
    logic [PW-1:0]       commit_addr_i [W];
    logic [W-1:0]        dispatch_valid_o;
    issue_uop_t          uop_o [W];

    // Staged stimulus and reference model state
    fetch_slot_t         next_slots [W];
    logic [PW-1:0]       next_caddr [W];
    logic [PW-1:0]       map_m [`ARCH_REGS];
    logic [PW-1:0]       free_q [$];
    logic [PW-1:0]       alloc_log [$];
    issue_uop_t          exp_uop [W];
    logic [W-1:0]        exp_valid;
    logic [W-1:0]        exp_hold;
    logic [W-1:0]        loaded;
    logic [31:0]         pc_next;
    string               test_name;
    int                  checks;
    int                  errors;
    int                  base_checks;
    int                  base_errors;
    int                  tests_run;
    int                  cycles;
    int unsigned         seed_sink;
    opcode_e             op_list [10] = '{OP, OP_IMM, LOAD, STORE, BRANCH,
                                          JAL, JALR, LUI, AUIPC, SYSTEM};

    issue_stage dut0 (.*);

    always #2 clk = ~clk;

    // ========================================
    // Reference model
    // ========================================

    // Decode by RV32I format, read map, allocate in lane order
    function automatic issue_uop_t predict_uop(input fetch_slot_t slot);
        logic [31:0] w;
        opcode_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        issue_uop_t  u;
        w   = slot.instr;
        op  = opcode_e'(w[6:0]);
        rd  = w[11:7];
        rs1 = (op == LUI || op == AUIPC || op == JAL) ? 5'd0 : w[19:15];
        rs2 = (op == OP || op == STORE || op == BRANCH) ? w[24:20] : 5'd0;
        u = '0;
        case (op)
            OP, OP_IMM, LOAD, JALR, LUI, AUIPC, JAL: u.rd_we = (rd != 5'd0);
            default: u.rd_we = 1'b0;
        endcase
        u.pc       = slot.pc;
        u.rs1_phys = map_m[rs1];
        u.rs2_phys = map_m[rs2];
        u.rd_arch  = rd;
        u.opcode   = op;
        if (u.rd_we) begin
            u.rd_phys = free_q.pop_front();
            map_m[rd] = u.rd_phys;
            alloc_log.push_back(u.rd_phys);
        end
        return u;
    endfunction

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            free_q.delete();
            alloc_log.delete();
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_m[i] = PW'(i);
                free_q.push_back(PW'(i + `ARCH_REGS));
            end
            exp_valid = '0;
            exp_hold  = '0;
            loaded    = '0;
        end else begin
            exp_valid = decode_valid_i & dispatch_ready_i & {W{free_q.size() >= 3}}
                        & {W{~(flush_i | bubble_i)}};
            // A stalled lane keeps its last micro-op
            exp_hold  = loaded & ~dispatch_ready_i;
            for (int k = 0; k < W; k++) begin
                if (exp_valid[k]) begin
                    exp_uop[k] = predict_uop(slots_i[k]);
                    loaded[k]  = 1'b1;
                end
            end
            for (int k = 0; k < W; k++) begin
                if (commit_valid_i[k]) begin
                    free_q.push_back(commit_addr_i[k]);
                end
            end
        end
    end

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_uop(input int lane, input issue_uop_t exp, input issue_uop_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: uop lane %0d expected %h actual %h", test_name, lane, exp, act);
        end
    endtask

    task automatic check_ready(input logic [W-1:0] exp, input logic [W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: decode ready expected %b actual %b", test_name, exp, act);
        end
    endtask

    task automatic check_valid(input logic [W-1:0] exp, input logic [W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: dispatch valid expected %b actual %b", test_name, exp, act);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset === 1'b1) begin
            check_valid(exp_valid, dispatch_valid_o);
            for (int k = 0; k < W; k++) begin
                if (exp_valid[k] || exp_hold[k]) begin
                    check_uop(k, exp_uop[k], uop_o[k]);
                end
            end
            check_ready(dispatch_ready_i & {W{free_q.size() >= 3}}, decode_ready_o);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic cycle_drive(input logic [W-1:0] valid, input logic [W-1:0] ready,
                               input logic flush, input logic bubble, input logic [W-1:0] cv);
        @(posedge clk);
        for (int k = 0; k < W; k++) begin
            slots_i[k]       <= next_slots[k];
            commit_addr_i[k] <= next_caddr[k];
        end
        decode_valid_i   <= valid;
        dispatch_ready_i <= ready;
        flush_i          <= flush;
        bubble_i         <= bubble;
        commit_valid_i   <= cv;
        @(negedge clk);
    endtask

    // Small register range so lanes collide often
    task automatic stage_group(input int kind);
        logic [31:0] w;
        for (int k = 0; k < W; k++) begin
            w        = $urandom;
            w[11:7]  = 5'($urandom_range(0, 7));
            w[19:15] = 5'($urandom_range(0, 7));
            w[24:20] = 5'($urandom_range(0, 7));
            case (kind)
                0: w[6:0] = op_list[$urandom_range(0, 9)];
                1: w[6:0] = (k == 1) ? BRANCH : STORE;
                default: begin
                    w[6:0]  = OP_IMM;
                    w[11:7] = 5'($urandom_range(1, 7));
                end
            endcase
            next_slots[k].instr = w;
            next_slots[k].pc    = pc_next;
            pc_next             = pc_next + 32'd4;
        end
    endtask

    // Retire the oldest allocations while the newest keep tags stay live
    function automatic logic [W-1:0] prep_commits(input int n, input int keep);
        logic [W-1:0] mask;
        mask = '0;
        for (int k = 0; k < W; k++) begin
            next_caddr[k] = '0;
            if (k < n && alloc_log.size() > keep) begin
                next_caddr[k] = alloc_log.pop_front();
                mask[k]       = 1'b1;
            end
        end
        return mask;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        base_checks = checks;
        base_errors = errors;
    endtask

    task automatic finish_test();
        cycle_drive('0, '1, 1'b0, 1'b0, '0);
        cycle_drive('0, '1, 1'b0, 1'b0, '0);
        #1;
        tests_run++;
        $display("%-14s checks %0d, errors %0d", test_name, checks - base_checks,
                 errors - base_errors);
    endtask

    initial begin
        seed_sink        = $urandom(59961);
        clk              = 1'b0;
        reset            = 1'b0;
        decode_valid_i   = '0;
        dispatch_ready_i = '0;
        flush_i          = 1'b0;
        bubble_i         = 1'b0;
        commit_valid_i   = '0;
        pc_next          = 32'h0000_1000;
        checks           = 0;
        errors           = 0;
        tests_run        = 0;
        cycles           = 0;
        for (int k = 0; k < W; k++) begin
            slots_i[k]       = '0;
            commit_addr_i[k] = '0;
            next_slots[k]    = '0;
            next_caddr[k]    = '0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);

        start_test("reset_idle");
        stage_group(1);
        cycle_drive('1, '1, 1'b0, 1'b0, '0);
        stage_group(1);
        cycle_drive('1, 3'b011, 1'b0, 1'b0, '0);
        finish_test();

        start_test("random_groups");
        repeat (10) begin
            stage_group(0);
            cycle_drive('1, '1, 1'b0, 1'b0, prep_commits(2, 8));
        end
        finish_test();

        start_test("backpressure");
        repeat (3) begin
            stage_group(0);
            cycle_drive('1, 3'b101, 1'b0, 1'b0, prep_commits(2, 8));
        end
        repeat (3) begin
            stage_group(2);
            cycle_drive(3'($urandom), 3'b010, 1'b0, 1'b0, prep_commits(2, 8));
        end
        finish_test();

        start_test("flush_bubble");
        stage_group(2);
        cycle_drive('1, '1, 1'b1, 1'b0, '0);
        stage_group(2);
        cycle_drive('1, '1, 1'b0, 1'b1, '0);
        stage_group(2);
        cycle_drive('1, '1, 1'b0, 1'b0, '0);
        finish_test();

        // Allocate until the free list can no longer cover a full group
        start_test("free_exhaust");
        do begin
            stage_group(2);
            cycle_drive('1, '1, 1'b0, 1'b0, '0);
        end while (decode_ready_o != '0);
        cycle_drive('1, '1, 1'b0, 1'b0, '0);
        check_ready('0, decode_ready_o);
        repeat (2) cycle_drive('1, '1, 1'b0, 1'b0, prep_commits(3, 0));
        while (decode_ready_o != '1) begin
            cycle_drive('1, '1, 1'b0, 1'b0, '0);
        end
        repeat (2) begin
            stage_group(2);
            cycle_drive('1, '1, 1'b0, 1'b0, '0);
        end
        finish_test();

        $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/issue_pkg.sv
src/issue_decoder.sv
src/rename_map.sv
src/free_list.sv
src/issue_pipe_reg.sv
src/issue_stage.sv
testbench/issue_stage_props.sv
testbench/issue_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f build.f \
    --top-module issue_stage_tb -Mdir obj_dir -o issue_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/issue_stage_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
